// File: filelist.f
logic/eth_pkg.sv
logic/stream_pkg.sv
logic/stream_dispatch.sv
logic/payload_queue.sv
logic/udp_header_gen.sv
logic/crc32_gen.sv
logic/frame_tx.sv
logic/udp_tx_top.sv
verif/udp_tx_assert.sv
verif/udp_tx_tb.sv

// File: verif/udp_tx_tb.sv
`timescale 1ns/1ps

module udp_tx_tb
    import eth_pkg::*, stream_pkg::*;
;

    localparam int CLK_PERIOD  = 40;
    localparam int SEED        = 25;
    localparam int NCH         = 4;
    localparam int DEPTH       = 256;
    localparam int PAYLOAD     = 24;
    localparam int BP_CH       = 2;

    localparam logic [47:0] FPGA_MAC  = 48'h02_00_00_00_00_10;
    localparam logic [31:0] FPGA_IP   = 32'hC0A8_0A02;
    localparam logic [15:0] FPGA_PORT = 16'd5000;
    localparam logic [47:0] HOST_MAC  = 48'h02_00_00_00_00_20;
    localparam logic [31:0] HOST_IP   = 32'hC0A8_0A01;
    localparam logic [15:0] HOST_PORT = 16'd6000;

    localparam int PRE_BYTES     = PREAMBLE_BYTES + SFD_BYTES;
    localparam int FRAME_BYTES   = PRE_BYTES + HEADER_BYTES + PAYLOAD + FCS_BYTES;
    localparam int MIN_IDLE      = GAP_BYTES + 2;  // gap plus IDLE and LOAD
    localparam int PRELOAD_BEATS = PAYLOAD * NCH;
    localparam int RAND_BEATS    = 600;
    localparam int BP_BEATS      = DEPTH + 160;
    localparam int IDLE_CYCLES   = 200;
    localparam int TOTAL_BEATS   = PRELOAD_BEATS + RAND_BEATS + BP_BEATS + BP_BEATS / 16;
    localparam int INPUT_CYCLES  = PRELOAD_BEATS + RAND_BEATS * 4 + BP_BEATS + BP_BEATS / 16;
    localparam int MAX_CYCLES    = 4 * (INPUT_CYCLES + IDLE_CYCLES
                                 + (TOTAL_BEATS / PAYLOAD + 1) * (FRAME_BYTES + MIN_IDLE));

    logic         clk;
    logic         rst;
    stream_beat_t s_beat;
    logic         s_valid;
    logic         s_ready;
    logic         tx_en;
    logic [7:0]   tx_d;

    logic [7:0] model_q [NCH][$];  // bytes accepted, not yet framed
    logic [7:0] rx[$];
    logic [7:0] expect_q[$];
    logic       in_frame = 1'b0;
    logic       bp_phase = 1'b0;
    int         low_run = 0;
    int         frames_seen = 0;
    int         stall_count = 0;
    int         checks = 0;
    int         errors = 0;
    int         cycles = 0;

    udp_tx_top #(
        .NUM_CHANNELS(NCH),
        .QUEUE_DEPTH (DEPTH)
    ) dut0 (
        .clk_i          (clk),
        .rst_i          (rst),
        .s_beat_i       (s_beat),
        .s_valid_i      (s_valid),
        .s_ready_o      (s_ready),
        .payload_bytes_i(16'(PAYLOAD)),
        .fpga_mac_i     (FPGA_MAC),
        .fpga_ip_i      (FPGA_IP),
        .fpga_port_i    (FPGA_PORT),
        .host_mac_i     (HOST_MAC),
        .host_ip_i      (HOST_IP),
        .host_port_i    (HOST_PORT),
        .tx_en_o        (tx_en),
        .tx_d_o         (tx_d)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    task automatic check_value(input logic [31:0] got, input logic [31:0] exp,
                               input string what);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("Fail at %0t: %s, got %0h, expected %0h", $time, what, got, exp);
        end
    endtask

    task automatic report_counts();
        $display("checks %0d, errors %0d, assertion failures %0d, frames %0d",
                 checks, errors, dut0.u_assert.fail_count, frames_seen);
    endtask

    // network order, most significant byte first
    function automatic void push_field(input logic [47:0] val, input int nbytes);
        for (int i = nbytes - 1; i >= 0; i--) begin
            expect_q.push_back(val[8*i +: 8]);
        end
    endfunction

    function automatic logic [15:0] ip_checksum(input int base);
        logic [31:0] sum;
        sum = '0;
        for (int k = 0; k < IPV4_HDR_BYTES; k += 2) begin
            sum = sum + {16'h0, expect_q[base+k], expect_q[base+k+1]};
        end
        while (sum[31:16] != '0) begin
            sum = {16'h0, sum[15:0]} + {16'h0, sum[31:16]};
        end
        return ~sum[15:0];
    endfunction

    // bitwise reflected crc-32 over expect_q from index first
    function automatic logic [31:0] crc32_of(input int first);
        logic [31:0] c;
        logic        fb;
        c = '1;
        for (int i = first; i < expect_q.size(); i++) begin
            for (int b = 0; b < 8; b++) begin
                fb = c[0] ^ expect_q[i][b];
                c  = c >> 1;
                if (fb) c = c ^ 32'hEDB88320;
            end
        end
        return ~c;
    endfunction

    function automatic void build_expected(input int ch, input int id);
        logic [15:0] csum;
        logic [31:0] fcs;
        expect_q.delete();
        repeat (PREAMBLE_BYTES) expect_q.push_back(8'h55);
        expect_q.push_back(8'hD5);
        push_field(HOST_MAC, 6);
        push_field(FPGA_MAC, 6);
        push_field(16'h0800, 2);
        push_field(8'h45, 1);
        push_field(8'h00, 1);
        push_field(16'(PAYLOAD + 28), 2);
        push_field(16'(id), 2);
        push_field(16'h4000, 2);
        push_field(8'd64, 1);
        push_field(8'd17, 1);
        push_field(16'h0000, 2);  // checksum filled below
        push_field(FPGA_IP, 4);
        push_field(HOST_IP, 4);
        push_field(FPGA_PORT + 16'(ch), 2);
        push_field(HOST_PORT, 2);
        push_field(16'(PAYLOAD + 8), 2);
        push_field(16'h0000, 2);
        csum = ip_checksum(PRE_BYTES + 14);
        expect_q[PRE_BYTES+24] = csum[15:8];
        expect_q[PRE_BYTES+25] = csum[7:0];
        repeat (PAYLOAD) expect_q.push_back(model_q[ch].pop_front());
        fcs = crc32_of(PRE_BYTES);
        for (int i = 0; i < FCS_BYTES; i++) begin
            expect_q.push_back(fcs[8*i +: 8]);  // lsb first
        end
    endfunction

    function automatic string section_of(input int i);
        if (i < PREAMBLE_BYTES) return "preamble";
        if (i < PRE_BYTES) return "sfd";
        if (i < PRE_BYTES + HEADER_BYTES) return "header";
        if (i < PRE_BYTES + HEADER_BYTES + PAYLOAD) return "payload";
        return "fcs";
    endfunction

    task automatic check_frame();
        logic [15:0] port;
        int          ch;
        check_value(rx.size(), FRAME_BYTES, "frame length");
        if (rx.size() == FRAME_BYTES) begin
            port = {rx[PRE_BYTES+34], rx[PRE_BYTES+35]};
            ch   = int'(port) - int'(FPGA_PORT);
            if (ch < 0 || ch >= NCH) begin
                errors++;
                $display("frame %0d carries source port %0d, which names no channel",
                         frames_seen, port);
            end else if (model_q[ch].size() < PAYLOAD) begin
                errors++;
                $display("frame %0d left channel %0d before a full payload was queued",
                         frames_seen, ch);
            end else begin
                if (frames_seen < NCH) begin
                    check_value(ch, frames_seen, "channel of a preloaded frame");
                end
                build_expected(ch, frames_seen);
                for (int i = 0; i < FRAME_BYTES; i++) begin
                    check_value(rx[i], expect_q[i],
                        $sformatf("frame %0d %s byte %0d", frames_seen, section_of(i), i));
                end
            end
        end
        frames_seen++;
    endtask

    // frame capture, sampled mid-cycle
    always @(negedge clk) begin
        if (!rst) begin
            if (tx_en) begin
                if (!in_frame) begin
                    if (frames_seen > 0 && low_run < MIN_IDLE) begin
                        errors++;
                        $display("idle time of %0d cycles before frame %0d is too short",
                                 low_run, frames_seen);
                    end
                    in_frame = 1'b1;
                    rx.delete();
                end
                rx.push_back(tx_d);
            end else begin
                if (in_frame) begin
                    in_frame = 1'b0;
                    check_frame();
                    low_run = 0;
                end
                low_run++;
            end
        end
    end

    task automatic send_beat(input ch_idx_t ch, input logic [7:0] data);
        logic accepted;
        int   waits;
        waits    = 0;
        accepted = 1'b0;
        s_valid <= 1'b1;
        s_beat  <= '{data: data, channel: ch};
        while (!accepted) begin
            @(negedge clk);
            accepted = s_ready;
            if (!accepted) begin
                waits++;
                if (waits == 1 && (!bp_phase || ch != ch_idx_t'(BP_CH))) begin
                    errors++;
                    $display("s_ready_o low for channel %0d, whose queue is not full", ch);
                end
            end
            @(posedge clk);
        end
        if (waits > 0) stall_count++;
        model_q[ch].push_back(data);
    endtask

    function automatic logic queues_busy();
        logic busy;
        busy = in_frame;
        for (int c = 0; c < NCH; c++) begin
            if (model_q[c].size() >= PAYLOAD) busy = 1'b1;
        end
        return busy;
    endfunction

    always @(posedge clk) begin
        cycles++;
        if (cycles > MAX_CYCLES) begin
            $display("run stopped after %0d cycles without finishing its traffic", cycles);
            report_counts();
            $display("TB FAILED");
            $finish;
        end
    end

    initial begin
        int          seed_init;
        int          gap;
        int          frames_before;
        ch_idx_t     other;
        seed_init = $urandom(SEED);
        rst     = 1'b1;
        s_valid = 1'b0;
        s_beat  = '0;
        repeat (4) @(posedge clk);
        rst <= 1'b0;
        @(posedge clk);

        // interleaved so every queue turns eligible within a few cycles
        for (int i = 0; i < PRELOAD_BEATS; i++) begin
            send_beat(ch_idx_t'(i % NCH), 8'($urandom));
        end

        for (int i = 0; i < RAND_BEATS; i++) begin
            send_beat(ch_idx_t'($urandom_range(NCH - 1)), 8'($urandom));
            gap = $urandom_range(3);
            if (gap > 0) begin
                s_valid <= 1'b0;
                repeat (gap) @(posedge clk);
            end
        end

        // one queue overfilled while its frames drain
        bp_phase = 1'b1;
        for (int i = 0; i < BP_BEATS; i++) begin
            send_beat(ch_idx_t'(BP_CH), 8'($urandom));
            if (i % 16 == 15) begin
                other = ch_idx_t'((BP_CH + 1 + $urandom_range(NCH - 2)) % NCH);
                send_beat(other, 8'($urandom));
            end
        end
        bp_phase = 1'b0;
        s_valid <= 1'b0;

        while (queues_busy()) @(posedge clk);
        frames_before = frames_seen;
        repeat (IDLE_CYCLES) @(posedge clk);
        check_value(frames_seen, frames_before, "frames sent with no queue eligible");
        check_value(in_frame, 1'b0, "frame in progress at end");
        if (stall_count == 0) begin
            errors++;
            $display("back-pressure never reached the source");
        end

        report_counts();
        if (errors == 0 && dut0.u_assert.fail_count == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule

// File: verif/udp_tx_assert.sv
`timescale 1ns/1ps

module udp_tx_assert
    import eth_pkg::*, stream_pkg::*;
#(
    parameter int NUM_CHANNELS = 4
) (
    input logic         clk_i,
    input logic         rst_i,
    input stream_beat_t beat_i,
    input logic         valid_i,
    input logic         ready_i,
    input logic [15:0]  payload_bytes_i,
    input logic         tx_en_i
);

    int          fail_count = 0;
    logic [15:0] high_len;  // cycles of the current burst
    logic [15:0] low_len;   // cycles since the last burst
    logic [15:0] burst_len;

    assign burst_len = 16'(PREAMBLE_BYTES + SFD_BYTES + HEADER_BYTES + FCS_BYTES)
                     + payload_bytes_i;

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            high_len <= '0;
            low_len  <= '0;
        end else begin
            high_len <= tx_en_i ? high_len + 16'd1 : '0;
            if (tx_en_i) begin
                low_len <= '0;
            end else if (low_len != '1) begin
                low_len <= low_len + 16'd1;  // saturates on long idle
            end
        end
    end

    tx_low_after_reset: assert property (@(posedge clk_i) rst_i |=> !tx_en_i)
        else begin
            fail_count++;
            $error("tx_en_o high right after reset");
        end

    burst_exact: assert property (@(posedge clk_i) disable iff (rst_i)
        $fell(tx_en_i) |-> high_len == burst_len)
        else begin
            fail_count++;
            $error("tx_en_o burst ended after %0d cycles", high_len);
        end

    burst_not_long: assert property (@(posedge clk_i) disable iff (rst_i)
        tx_en_i |-> high_len < burst_len)
        else begin
            fail_count++;
            $error("tx_en_o burst runs past its length");
        end

    gap_min: assert property (@(posedge clk_i) disable iff (rst_i)
        $rose(tx_en_i) |-> low_len >= 16'(GAP_BYTES))
        else begin
            fail_count++;
            $error("inter-frame gap of %0d cycles", low_len);
        end

    no_bad_channel: assert property (@(posedge clk_i) disable iff (rst_i)
        (valid_i && !ch_in_range(beat_i.channel, NUM_CHANNELS)) |-> !ready_i)
        else begin
            fail_count++;
            $error("out-of-range channel accepted");
        end

endmodule

bind udp_tx_top udp_tx_assert #(
    .NUM_CHANNELS(NUM_CHANNELS)
) u_assert (
    .clk_i          (clk_i),
    .rst_i          (rst_i),
    .beat_i         (s_beat_i),
    .valid_i        (s_valid_i),
    .ready_i        (s_ready_o),
    .payload_bytes_i(payload_bytes_i),
    .tx_en_i        (tx_en_o)
);

// File: logic/udp_tx_top.sv
`timescale 1ns/1ps

module udp_tx_top
    import eth_pkg::*, stream_pkg::*;
#(
    parameter int NUM_CHANNELS = 4,
    parameter int QUEUE_DEPTH  = 2048
) (
    input  logic         clk_i,
    input  logic         rst_i,

    input  stream_beat_t s_beat_i,
    input  logic         s_valid_i,
    output logic         s_ready_o,

    input  logic [15:0]  payload_bytes_i,
    input  logic [47:0]  fpga_mac_i,
    input  logic [31:0]  fpga_ip_i,
    input  logic [15:0]  fpga_port_i,
    input  logic [47:0]  host_mac_i,
    input  logic [31:0]  host_ip_i,
    input  logic [15:0]  host_port_i,

    output logic         tx_en_o,
    output logic [7:0]   tx_d_o
);

    logic [NUM_CHANNELS-1:0] q_valid;
    logic [7:0]              q_data;
    logic [NUM_CHANNELS-1:0] q_ready;
    logic [NUM_CHANNELS-1:0] rd_valid;
    logic [NUM_CHANNELS-1:0] rd_ready;
    logic [7:0]              rd_data [NUM_CHANNELS];
    queue_status_t           status [NUM_CHANNELS];
    ch_idx_t                 hdr_channel;
    logic                    hdr_load;
    eth_header_u             header;

    stream_dispatch #(
        .NUM_CHANNELS(NUM_CHANNELS)
    ) i_dispatch (
        .s_beat_i (s_beat_i),
        .s_valid_i(s_valid_i),
        .s_ready_o(s_ready_o),
        .q_valid_o(q_valid),
        .q_data_o (q_data),
        .q_ready_i(q_ready)
    );

    for (genvar i = 0; i < NUM_CHANNELS; i++) begin : g_queue
        payload_queue #(
            .QUEUE_DEPTH(QUEUE_DEPTH)
        ) i_queue (
            .clk_i     (clk_i),
            .rst_i     (rst_i),
            .wr_valid_i(q_valid[i]),
            .wr_data_i (q_data),
            .wr_ready_o(q_ready[i]),
            .rd_valid_o(rd_valid[i]),
            .rd_data_o (rd_data[i]),
            .rd_ready_i(rd_ready[i]),
            .status_o  (status[i])
        );
    end

    udp_header_gen i_header_gen (
        .clk_i          (clk_i),
        .channel_i      (hdr_channel),
        .load_i         (hdr_load),
        .payload_bytes_i(payload_bytes_i),
        .fpga_mac_i     (fpga_mac_i),
        .fpga_ip_i      (fpga_ip_i),
        .fpga_port_i    (fpga_port_i),
        .host_mac_i     (host_mac_i),
        .host_ip_i      (host_ip_i),
        .host_port_i    (host_port_i),
        .header_o       (header)
    );

    frame_tx #(
        .NUM_CHANNELS(NUM_CHANNELS)
    ) i_frame_tx (
        .clk_i          (clk_i),
        .rst_i          (rst_i),
        .payload_bytes_i(payload_bytes_i),
        .status_i       (status),
        .rd_valid_i     (rd_valid),
        .rd_data_i      (rd_data),
        .rd_ready_o     (rd_ready),
        .hdr_channel_o  (hdr_channel),
        .hdr_load_o     (hdr_load),
        .header_i       (header),
        .tx_en_o        (tx_en_o),
        .tx_d_o         (tx_d_o)
    );

endmodule

// File: logic/frame_tx.sv
`timescale 1ns/1ps

module frame_tx
    import eth_pkg::*, stream_pkg::*;
#(
    parameter int NUM_CHANNELS = 4
) (
    input  logic                    clk_i,
    input  logic                    rst_i,
    input  logic [15:0]             payload_bytes_i,

    input  queue_status_t           status_i [NUM_CHANNELS],
    input  logic [NUM_CHANNELS-1:0] rd_valid_i,
    input  logic [7:0]              rd_data_i [NUM_CHANNELS],
    output logic [NUM_CHANNELS-1:0] rd_ready_o,

    output ch_idx_t                 hdr_channel_o,
    output logic                    hdr_load_o,
    input  eth_header_u             header_i,

    output logic                    tx_en_o,
    output logic [7:0]              tx_d_o
);

    typedef enum logic [2:0] {
        IDLE, LOAD, PREAMBLE, SFD, HEADER, DATA, FCS, GAP
    } state_t;

    state_t                       state, state_next;
    logic [15:0]                  state_cnt;
    ch_idx_t                      sel_ch;  // served channel, also the rr pointer
    ch_idx_t                      scan_ch;
    ch_idx_t                      pick_ch;
    logic                         pick_found;
    logic [HEADER_BYTES-1:0][7:0] hdr_buf;
    logic [FCS_BYTES*8-1:0]       fcs_buf;
    logic [FCS_BYTES*8-1:0]       fcs_word;
    logic [31:0]                  crc;
    logic [7:0]                   tx_data;
    logic                         tx_valid;
    logic                         crc_en;

    // first eligible queue after the last one served
    always_comb begin
        pick_found = 1'b0;
        pick_ch    = sel_ch;
        scan_ch    = sel_ch;
        for (int k = 0; k < NUM_CHANNELS; k++) begin
            scan_ch = next_channel(scan_ch, NUM_CHANNELS);
            if (!pick_found && status_i[scan_ch].count >= payload_bytes_i) begin
                pick_found = 1'b1;
                pick_ch    = scan_ch;
            end
        end
    end

    always_comb begin
        state_next = state;
        case (state)
            IDLE:     if (pick_found) state_next = LOAD;
            LOAD:     state_next = PREAMBLE;
            PREAMBLE: if (state_cnt == PREAMBLE_BYTES - 1) state_next = SFD;
            SFD:      if (state_cnt == SFD_BYTES - 1) state_next = HEADER;
            HEADER:   if (state_cnt == HEADER_BYTES - 1) state_next = DATA;
            DATA:     if (state_cnt == payload_bytes_i - 16'd1) state_next = FCS;
            FCS:      if (state_cnt == FCS_BYTES - 1) state_next = GAP;
            GAP:      if (state_cnt == GAP_BYTES - 1) state_next = IDLE;
            default:  state_next = IDLE;
        endcase
    end

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            state     <= IDLE;
            state_cnt <= '0;
            sel_ch    <= CH_W'(NUM_CHANNELS - 1);  // first scan starts at 0
        end else begin
            state     <= state_next;
            state_cnt <= (state_next != state) ? '0 : state_cnt + 16'd1;
            if (state == IDLE && pick_found) begin
                sel_ch <= pick_ch;
            end
        end
    end

    assign hdr_load_o    = (state == LOAD);
    assign hdr_channel_o = sel_ch;

    // crc register is complete one cycle after the last payload byte
    assign fcs_word = (state_cnt == '0) ? crc : fcs_buf;

    always_comb begin
        tx_valid = 1'b0;
        tx_data  = 8'h00;
        crc_en   = 1'b0;
        case (state)
            PREAMBLE: begin
                tx_valid = 1'b1;
                tx_data  = PREAMBLE_VAL;
            end
            SFD: begin
                tx_valid = 1'b1;
                tx_data  = SFD_VAL;
            end
            HEADER: begin
                tx_valid = 1'b1;
                tx_data  = hdr_buf[HEADER_BYTES-1];
                crc_en   = 1'b1;
            end
            DATA: begin
                tx_valid = rd_valid_i[sel_ch];
                tx_data  = rd_data_i[sel_ch];
                crc_en   = 1'b1;
            end
            FCS: begin
                tx_valid = 1'b1;
                tx_data  = fcs_word[7:0];  // lsb first
            end
            default: begin
                tx_valid = 1'b0;
            end
        endcase
    end

    always_comb begin
        for (int i = 0; i < NUM_CHANNELS; i++) begin
            rd_ready_o[i] = (state == DATA) && (sel_ch == CH_W'(i));
        end
    end

    always_ff @(posedge clk_i) begin
        if (state == SFD) begin
            hdr_buf <= header_i.bytes;
        end else if (state == HEADER) begin
            hdr_buf <= {hdr_buf[HEADER_BYTES-2:0], 8'h00};
        end
        if (state == FCS) begin
            fcs_buf <= fcs_word >> 8;
        end
        tx_d_o <= tx_data;
    end

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            tx_en_o <= 1'b0;
        end else begin
            tx_en_o <= tx_valid;
        end
    end

    crc32_gen i_crc (
        .clk_i  (clk_i),
        .clear_i(state == IDLE),
        .en_i   (crc_en),
        .data_i (tx_data),
        .crc_o  (crc)
    );

endmodule

// File: logic/crc32_gen.sv
`timescale 1ns/1ps

module crc32_gen (
    input  logic        clk_i,
    input  logic        clear_i,
    input  logic        en_i,
    input  logic [7:0]  data_i,
    output logic [31:0] crc_o
);

    localparam logic [31:0] POLY = 32'hEDB88320;  // reflected 0x04C11DB7

    logic [31:0] crc_q;

    // one byte, lsb first
    function automatic logic [31:0] crc_step(input logic [31:0] crc, input logic [7:0] data);
        logic [31:0] r;
        r = crc ^ {24'h0, data};
        for (int b = 0; b < 8; b++) begin
            r = r[0] ? ((r >> 1) ^ POLY) : (r >> 1);
        end
        return r;
    endfunction

    always_ff @(posedge clk_i) begin
        if (clear_i) begin
            crc_q <= '1;
        end else if (en_i) begin
            crc_q <= crc_step(crc_q, data_i);
        end
    end

    assign crc_o = ~crc_q;

endmodule

// File: logic/udp_header_gen.sv
`timescale 1ns/1ps

module udp_header_gen
    import eth_pkg::*, stream_pkg::*;
(
    input  logic        clk_i,
    input  ch_idx_t     channel_i,
    input  logic        load_i,
    input  logic [15:0] payload_bytes_i,

    input  logic [47:0] fpga_mac_i,
    input  logic [31:0] fpga_ip_i,
    input  logic [15:0] fpga_port_i,

    input  logic [47:0] host_mac_i,
    input  logic [31:0] host_ip_i,
    input  logic [15:0] host_port_i,

    output eth_header_u header_o
);

    localparam int IP_TOP   = HEADER_BYTES - 1 - MAC_HDR_BYTES;  // first ipv4 byte
    localparam int IP_WORDS = IPV4_HDR_BYTES / 2;

    eth_header_u hdr_next;
    logic [19:0] sum_raw;
    logic [16:0] sum_fold;
    logic [15:0] frame_id = '0;

    always_comb begin
        hdr_next = '0;
        hdr_next.fields.dst_mac       = host_mac_i;
        hdr_next.fields.src_mac       = fpga_mac_i;
        hdr_next.fields.ethertype     = ETHERTYPE_IPV4;
        hdr_next.fields.ip_ver_ihl    = IPV4_VER_IHL;
        hdr_next.fields.ip_total_len  = 16'(payload_bytes_i + IPV4_HDR_BYTES + UDP_HDR_BYTES);
        hdr_next.fields.ip_id         = frame_id;
        hdr_next.fields.ip_flags_frag = IPV4_FLAGS;
        hdr_next.fields.ip_ttl        = IPV4_TTL;
        hdr_next.fields.ip_proto      = IPV4_PROTO_UDP;
        hdr_next.fields.src_ip        = fpga_ip_i;
        hdr_next.fields.dst_ip        = host_ip_i;
        hdr_next.fields.udp_src_port  = fpga_port_i + 16'(channel_i);
        hdr_next.fields.udp_dst_port  = host_port_i;
        hdr_next.fields.udp_len       = 16'(payload_bytes_i + UDP_HDR_BYTES);

        // checksum field is still zero here
        sum_raw = '0;
        for (int k = 0; k < IP_WORDS; k++) begin
            sum_raw = sum_raw + {4'h0, hdr_next.bytes[IP_TOP-2*k], hdr_next.bytes[IP_TOP-2*k-1]};
        end
        sum_fold = {1'b0, sum_raw[15:0]} + {13'h0, sum_raw[19:16]};
        // second fold cannot carry again
        hdr_next.fields.ip_checksum = ~(sum_fold[15:0] + {15'h0, sum_fold[16]});
    end

    always_ff @(posedge clk_i) begin
        if (load_i) begin
            header_o <= hdr_next;
            frame_id <= frame_id + 16'd1;  // ip identification per frame
        end
    end

endmodule

// File: logic/payload_queue.sv
`timescale 1ns/1ps

module payload_queue
    import stream_pkg::*;
#(
    parameter int QUEUE_DEPTH = 2048
) (
    input  logic          clk_i,
    input  logic          rst_i,

    input  logic          wr_valid_i,
    input  logic [7:0]    wr_data_i,
    output logic          wr_ready_o,

    output logic          rd_valid_o,
    output logic [7:0]    rd_data_o,
    input  logic          rd_ready_i,

    output queue_status_t status_o
);

    localparam int AW = $clog2(QUEUE_DEPTH);

    logic [7:0]    mem [QUEUE_DEPTH];
    logic [AW-1:0] wr_ptr;
    logic [AW-1:0] rd_ptr;
    logic [AW:0]   count;
    logic          do_wr;
    logic          do_rd;

    assign wr_ready_o = (count != (AW + 1)'(QUEUE_DEPTH));
    assign rd_valid_o = (count != '0);
    assign rd_data_o  = mem[rd_ptr];  // head shows without a read

    assign do_wr = wr_valid_i && wr_ready_o;
    assign do_rd = rd_ready_i && rd_valid_o;

    always_ff @(posedge clk_i) begin
        if (do_wr) begin
            mem[wr_ptr] <= wr_data_i;
        end
    end

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_wr) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (do_rd) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({do_wr, do_rd})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;  // both or neither
            endcase
        end
    end

    assign status_o.count = QCOUNT_W'(count);

endmodule

// File: logic/stream_dispatch.sv
`timescale 1ns/1ps

module stream_dispatch
    import stream_pkg::*;
#(
    parameter int NUM_CHANNELS = 4
) (
    input  stream_beat_t            s_beat_i,
    input  logic                    s_valid_i,
    output logic                    s_ready_o,

    output logic [NUM_CHANNELS-1:0] q_valid_o,
    output logic [7:0]              q_data_o,
    input  logic [NUM_CHANNELS-1:0] q_ready_i
);

    logic [NUM_CHANNELS-1:0] hit;  // one-hot destination

    // out-of-range channels match no bit
    always_comb begin
        for (int i = 0; i < NUM_CHANNELS; i++) begin
            hit[i] = (s_beat_i.channel == CH_W'(i));
        end
    end

    assign q_valid_o = hit & {NUM_CHANNELS{s_valid_i}};
    assign q_data_o  = s_beat_i.data;

    // only the addressed queue can stall the source
    assign s_ready_o = |(hit & q_ready_i);

endmodule

// File: logic/stream_pkg.sv
package stream_pkg;

    localparam int CH_W     = 2;
    localparam int QCOUNT_W = 16;

    typedef logic [CH_W-1:0] ch_idx_t;

    typedef struct packed {
        logic [7:0] data;
        ch_idx_t    channel;
    } stream_beat_t;

    typedef struct packed {
        logic [QCOUNT_W-1:0] count;  // bytes held
    } queue_status_t;

    function automatic logic ch_in_range(input ch_idx_t ch, input int num);
        return int'(ch) < num;
    endfunction

    function automatic ch_idx_t next_channel(input ch_idx_t ch, input int num);
        return (int'(ch) >= num - 1) ? '0 : ch + 1'b1;  // wraps at num
    endfunction

endpackage

// File: logic/eth_pkg.sv
package eth_pkg;

    // frame section lengths in bytes
    localparam int PREAMBLE_BYTES = 7;
    localparam int SFD_BYTES      = 1;
    localparam int HEADER_BYTES   = 42;
    localparam int FCS_BYTES      = 4;
    localparam int GAP_BYTES      = 12;

    localparam int MAC_HDR_BYTES  = 14;
    localparam int IPV4_HDR_BYTES = 20;
    localparam int UDP_HDR_BYTES  = 8;

    localparam logic [7:0] PREAMBLE_VAL = 8'h55;
    localparam logic [7:0] SFD_VAL      = 8'hD5;

    localparam logic [15:0] ETHERTYPE_IPV4 = 16'h0800;
    localparam logic [7:0]  IPV4_VER_IHL   = 8'h45;  // v4, 5 words
    localparam logic [15:0] IPV4_FLAGS     = 16'h4000;  // don't fragment
    localparam logic [7:0]  IPV4_TTL       = 8'd64;
    localparam logic [7:0]  IPV4_PROTO_UDP = 8'd17;

    // first field is the first byte on the wire
    typedef struct packed {
        logic [47:0] dst_mac;
        logic [47:0] src_mac;
        logic [15:0] ethertype;
        logic [7:0]  ip_ver_ihl;
        logic [7:0]  ip_tos;
        logic [15:0] ip_total_len;
        logic [15:0] ip_id;
        logic [15:0] ip_flags_frag;
        logic [7:0]  ip_ttl;
        logic [7:0]  ip_proto;
        logic [15:0] ip_checksum;
        logic [31:0] src_ip;
        logic [31:0] dst_ip;
        logic [15:0] udp_src_port;
        logic [15:0] udp_dst_port;
        logic [15:0] udp_len;
        logic [15:0] udp_checksum;
    } eth_header_t;

    typedef union packed {
        eth_header_t                  fields;
        logic [HEADER_BYTES-1:0][7:0] bytes;  // bytes[HEADER_BYTES-1] goes out first
    } eth_header_u;

endpackage
